/* hci.f */
logic/hci_pkg.sv
logic/hci_csr_pkg.sv
logic/hci_fifo.sv
logic/hci_cmd_queue.sv
logic/hci_resp_queue.sv
logic/hci_csr.sv
logic/hci.sv
test/tb_hci.sv

/* Makefile */
TOOL      := verilator
VFLAGS    := --timing -Wno-fatal
TOP       := tb_hci
FILELIST  := hci.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := SIMULATION PASSED
FAIL_MSG  := SIMULATION FAILED

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/tb_hci.sv */
// ==========================================================================
// Testbench for the HCI queues. Assumes one CPU master and depths below 256
// ==========================================================================
`timescale 1ns/10ps

module tb_hci
  import hci_pkg::*;
  import hci_csr_pkg::*;
();

  localparam int unsigned CmdDepth  = 8;
  localparam int unsigned RespDepth = 8;
  localparam int NumCmdPairs = 20;
  localparam int NumResps    = 12;
  // A few hundred CSR accesses of under 10 cycles each, with wide margin
  localparam int TimeoutCycles = 20000;

  logic       clk;
  logic       rst_n;
  csr_req_t   csr_req;
  csr_rsp_t   csr_rsp;
  ctrl_cmd_t  cmd;
  logic       cmd_rready;
  ctrl_resp_t resp_drv;
  logic       resp_wready;
  logic       cmd_thld_trig, resp_thld_trig;
  addr_upd_t  addr_upd;

  // Reference model state
  logic [CmdDataW-1:0]  cmd_exp[$];
  logic [RespDataW-1:0] resp_exp[$];
  int                   cmd_thld, resp_thld;
  logic [31:0]          dev_addr_exp;
  int                   cycle_cnt = 0;

  hci #(
    .CmdDepth  (CmdDepth),
    .RespDepth (RespDepth)
  ) hci_i (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .csr_req_i        (csr_req),
    .csr_rsp_o        (csr_rsp),
    .cmd_o            (cmd),
    .cmd_rready_i     (cmd_rready),
    .resp_i           (resp_drv),
    .resp_wready_o    (resp_wready),
    .cmd_thld_trig_o  (cmd_thld_trig),
    .resp_thld_trig_o (resp_thld_trig),
    .addr_upd_i       (addr_upd)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  function automatic logic [63:0] ref_cmd(input logic [31:0] lo, input logic [31:0] hi);
    return {hi, lo};  // First dword is the low half
  endfunction

  function automatic logic [31:0] ref_status(input int cmd_cnt, input int resp_cnt);
    logic [31:0] s;
    s        = '0;
    s[0]     = (cmd_cnt == CmdDepth);
    s[1]     = (cmd_cnt == 0);
    s[2]     = (resp_cnt == RespDepth);
    s[3]     = (resp_cnt == 0);
    s[15:8]  = cmd_cnt[7:0];
    s[23:16] = resp_cnt[7:0];
    return s;
  endfunction

  function automatic logic ref_trig(input int level, input int thld);
    return level >= ((thld == 0) ? 1 : thld);
  endfunction

  function automatic logic [31:0] ref_dev_addr(input logic [31:0] cur, input logic dasa,
      input logic rstdaa, input logic newda, input logic [6:0] addr);
    if (dasa) begin
      return {1'b1, 24'd0, addr};
    end else if (rstdaa) begin
      return '0;
    end else if (newda) begin
      return {1'b1, 24'd0, addr};
    end
    return cur;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at cycle %0d", cycle_cnt);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      abort_run("Timeout: the tests did not finish within the cycle limit");
    end
  end

  // Every command the controller takes must be the oldest expected one
  always @(posedge clk) begin
    if (rst_n && cmd.rvalid && cmd_rready) begin
      if (cmd_exp.size() == 0) begin
        abort_run("Controller received a command that software never wrote");
      end else begin
        check("cmd_o.rdata", cmd.rdata, cmd_exp.pop_front());
      end
    end
  end

  task automatic csr_access(input logic is_wr, input logic [CsrAddrW-1:0] addr,
      input logic [CsrDataW-1:0] wdata, output logic [CsrDataW-1:0] rdata,
      output logic err);
    @(posedge clk);
    csr_req <= '{req: 1'b1, is_wr: is_wr, addr: addr, wr_data: wdata};
    @(posedge clk);
    csr_req.req <= 1'b0;
    do @(posedge clk); while (!(is_wr ? csr_rsp.wr_ack : csr_rsp.rd_ack));
    rdata = csr_rsp.rd_data;
    err   = is_wr ? csr_rsp.wr_err : csr_rsp.rd_err;
  endtask

  task automatic csr_write(input logic [CsrAddrW-1:0] addr, input logic [CsrDataW-1:0] data);
    logic [CsrDataW-1:0] rd;
    logic                err;
    csr_access(1'b1, addr, data, rd, err);
    check("csr_rsp_o.wr_err", err, 1'b0);
  endtask

  task automatic csr_read(input logic [CsrAddrW-1:0] addr, output logic [CsrDataW-1:0] data);
    logic err;
    csr_access(1'b0, addr, '0, data, err);
    check("csr_rsp_o.rd_err", err, 1'b0);
  endtask

  task automatic write_cmd(input logic [31:0] lo, input logic [31:0] hi);
    csr_write(REG_COMMAND_PORT, lo);
    csr_write(REG_COMMAND_PORT, hi);
    cmd_exp.push_back(ref_cmd(lo, hi));
  endtask

  task automatic pop_cmd();
    @(posedge clk);
    cmd_rready <= 1'b1;
    @(posedge clk);
    cmd_rready <= 1'b0;
  endtask

  task automatic drain_cmds();
    cmd_rready <= 1'b1;
    while (cmd_exp.size() != 0) @(posedge clk);
    cmd_rready <= 1'b0;
  endtask

  task automatic push_resp(input logic [31:0] data);
    @(posedge clk);
    resp_drv <= '{wvalid: 1'b1, wdata: data};
    do @(posedge clk); while (!resp_wready);
    resp_drv.wvalid <= 1'b0;
    resp_exp.push_back(data);
  endtask

  task automatic read_resp();
    logic [CsrDataW-1:0] data;
    csr_read(REG_RESPONSE_PORT, data);
    if (resp_exp.size() == 0) begin
      abort_run("Response port returned data while no response was queued");
    end else begin
      check("csr_rsp_o.rd_data", data, resp_exp.pop_front());
    end
  endtask

  task automatic check_status();
    logic [CsrDataW-1:0] rd;
    csr_read(REG_QUEUE_STATUS, rd);
    check("REG_QUEUE_STATUS", rd, ref_status(cmd_exp.size(), resp_exp.size()));
    check("cmd_thld_trig_o", cmd_thld_trig, ref_trig(CmdDepth - cmd_exp.size(), cmd_thld));
    check("resp_thld_trig_o", resp_thld_trig, ref_trig(resp_exp.size(), resp_thld));
  endtask

  task automatic addr_strobe(input logic dasa, input logic rstdaa, input logic newda,
      input logic [6:0] addr);
    logic [CsrDataW-1:0] rd;
    @(posedge clk);
    addr_upd <= '{set_dasa: dasa, rstdaa: rstdaa, set_newda: newda, addr: addr};
    @(posedge clk);
    addr_upd <= '0;
    dev_addr_exp = ref_dev_addr(dev_addr_exp, dasa, rstdaa, newda, addr);
    csr_read(REG_DEVICE_ADDR, rd);
    check("REG_DEVICE_ADDR", rd, dev_addr_exp);
  endtask

  initial begin
    logic [CsrDataW-1:0] rd;
    logic                err;
    bit                  writes_done, empty_read_done;
    void'($urandom(32'h9bdbc52a));
    rst_n        = 1'b0;
    csr_req      = '0;
    cmd_rready   = 1'b0;
    resp_drv     = '0;
    addr_upd     = '0;
    cmd_thld     = 0;
    resp_thld    = 0;
    dev_addr_exp = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    // Reset values
    check_status();
    csr_read(REG_DEVICE_ADDR, rd);
    check("REG_DEVICE_ADDR", rd, 32'h0);
    check("resp_wready_o", resp_wready, 1'b1);
    check("cmd_o.rvalid", cmd.rvalid, 1'b0);

    // Fill the command queue, then stall one write on the full queue
    for (int i = 0; i < CmdDepth; i++) write_cmd($urandom, $urandom);
    check_status();
    writes_done = 1'b0;
    fork
      begin
        for (int i = CmdDepth; i < NumCmdPairs; i++) write_cmd($urandom, $urandom);
        writes_done = 1'b1;
      end
      begin
        repeat (20) @(posedge clk);
        check("command entries while stalled", cmd_exp.size(), CmdDepth);
        while (!writes_done) begin
          cmd_rready <= ($urandom_range(3) == 0);
          @(posedge clk);
        end
      end
    join
    drain_cmds();

    // Responses with random gaps, read back in order
    fork
      for (int i = 0; i < NumResps; i++) begin
        push_resp($urandom);
        repeat ($urandom_range(4)) @(posedge clk);
      end
      for (int i = 0; i < NumResps; i++) read_resp();
    join
    empty_read_done = 1'b0;
    fork
      begin
        read_resp();  // Queue is empty here
        empty_read_done = 1'b1;
      end
      begin
        repeat (10) @(posedge clk);
        check("empty response read done early", empty_read_done, 1'b0);
        push_resp($urandom);
      end
    join
    check_status();

    // Thresholds, stepwise fill and drain
    cmd_thld  = $urandom_range(CmdDepth, 1);
    resp_thld = $urandom_range(RespDepth, 1);
    csr_write(REG_QUEUE_THLD, {16'h0, 8'(resp_thld), 8'(cmd_thld)});
    csr_read(REG_QUEUE_THLD, rd);
    check("REG_QUEUE_THLD", rd, {16'h0, 8'(resp_thld), 8'(cmd_thld)});
    for (int i = 0; i < CmdDepth; i++) begin
      write_cmd($urandom, $urandom);
      check_status();
    end
    for (int i = 0; i < CmdDepth; i++) begin
      pop_cmd();
      check_status();
    end
    for (int i = 0; i < RespDepth; i++) begin
      push_resp($urandom);
      check_status();
    end
    check("resp_wready_o", resp_wready, 1'b0);
    for (int i = 0; i < RespDepth; i++) begin
      read_resp();
      check_status();
    end
    csr_access(1'b1, 12'h020, 32'h1234_5678, rd, err);
    check("wr_err on unknown offset", err, 1'b1);
    csr_access(1'b0, 12'h018, '0, rd, err);
    check("rd_err on unknown offset", err, 1'b1);
    csr_access(1'b0, REG_COMMAND_PORT, '0, rd, err);
    check("rd_err on command port", err, 1'b1);
    csr_access(1'b1, REG_RESPONSE_PORT, '0, rd, err);
    check("wr_err on response port", err, 1'b1);

    // Queue resets with a half-built command pending
    for (int i = 0; i < 3; i++) write_cmd($urandom, $urandom);
    csr_write(REG_COMMAND_PORT, $urandom);
    for (int i = 0; i < 3; i++) push_resp($urandom);
    check_status();
    csr_write(REG_RESET_CONTROL, 32'h2);
    cmd_exp.delete();
    csr_read(REG_RESET_CONTROL, rd);
    check("REG_RESET_CONTROL", rd, 32'h0);
    check_status();
    csr_write(REG_RESET_CONTROL, 32'h4);
    resp_exp.delete();
    csr_read(REG_RESET_CONTROL, rd);
    check("REG_RESET_CONTROL", rd, 32'h0);
    check_status();
    write_cmd($urandom, $urandom);  // Must start from a fresh low dword
    drain_cmds();

    // All strobe combinations, twice, with random addresses
    for (int i = 0; i < 16; i++) addr_strobe(i[2], i[1], i[0], 7'($urandom));

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule : tb_hci

/* logic/hci.sv */
// ==========================================================================
// Cut-down I3C HCI, command and response queues only. Depths below 256
// ==========================================================================
`timescale 1ns/10ps

module hci
  import hci_pkg::*;
  import hci_csr_pkg::*;
#(
  parameter int unsigned CmdDepth  = 8,
  parameter int unsigned RespDepth = 8
) (
  input  logic       clk_i,
  input  logic       rst_ni,

  // Software register access
  input  csr_req_t   csr_req_i,
  output csr_rsp_t   csr_rsp_o,

  // Controller side
  output ctrl_cmd_t  cmd_o,
  input  logic       cmd_rready_i,
  input  ctrl_resp_t resp_i,
  output logic       resp_wready_o,

  output logic       cmd_thld_trig_o,
  output logic       resp_thld_trig_o,

  input  addr_upd_t  addr_upd_i
);

  logic                 cmd_wr, cmd_ack;
  logic [CsrDataW-1:0]  cmd_wdata;
  logic                 resp_rd, resp_ack;
  logic [RespDataW-1:0] resp_data;
  logic                 cmd_flush, resp_flush;
  logic                 cmd_flush_done, resp_flush_done;
  logic [QueueCntW-1:0] cmd_thld, resp_thld;
  queue_status_t        cmd_status, resp_status;

  hci_csr csr_i (
    .clk_i,
    .rst_ni,
    .csr_req_i,
    .csr_rsp_o,
    .cmd_wr_o          (cmd_wr),
    .cmd_wdata_o       (cmd_wdata),
    .cmd_ack_i         (cmd_ack),
    .resp_rd_o         (resp_rd),
    .resp_ack_i        (resp_ack),
    .resp_data_i       (resp_data),
    .cmd_flush_o       (cmd_flush),
    .resp_flush_o      (resp_flush),
    .cmd_flush_done_i  (cmd_flush_done),
    .resp_flush_done_i (resp_flush_done),
    .cmd_thld_o        (cmd_thld),
    .resp_thld_o       (resp_thld),
    .cmd_status_i      (cmd_status),
    .resp_status_i     (resp_status),
    .addr_upd_i
  );

  hci_cmd_queue #(
    .Depth (CmdDepth)
  ) cmd_queue_i (
    .clk_i,
    .rst_ni,
    .flush_i      (cmd_flush),
    .port_wr_i    (cmd_wr),
    .port_data_i  (cmd_wdata),
    .port_ack_o   (cmd_ack),
    .thld_i       (cmd_thld),
    .cmd_o,
    .cmd_rready_i,
    .status_o     (cmd_status),
    .flush_done_o (cmd_flush_done)
  );

  hci_resp_queue #(
    .Depth (RespDepth)
  ) resp_queue_i (
    .clk_i,
    .rst_ni,
    .flush_i       (resp_flush),
    .resp_i,
    .resp_wready_o,
    .port_rd_i     (resp_rd),
    .port_ack_o    (resp_ack),
    .port_data_o   (resp_data),
    .thld_i        (resp_thld),
    .status_o      (resp_status),
    .flush_done_o  (resp_flush_done)
  );

  assign cmd_thld_trig_o  = cmd_status.thld_trig;
  assign resp_thld_trig_o = resp_status.thld_trig;

endmodule : hci

/* logic/hci_csr.sv */
// ==========================================================================
// One request in flight. Port accesses are acked by the queues, not here
// ==========================================================================
`timescale 1ns/10ps

module hci_csr
  import hci_pkg::*;
  import hci_csr_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  csr_req_t             csr_req_i,
  output csr_rsp_t             csr_rsp_o,

  output logic                 cmd_wr_o,
  output logic [CsrDataW-1:0]  cmd_wdata_o,
  input  logic                 cmd_ack_i,

  output logic                 resp_rd_o,
  input  logic                 resp_ack_i,
  input  logic [RespDataW-1:0] resp_data_i,

  output logic                 cmd_flush_o,
  output logic                 resp_flush_o,
  input  logic                 cmd_flush_done_i,
  input  logic                 resp_flush_done_i,

  output logic [QueueCntW-1:0] cmd_thld_o,
  output logic [QueueCntW-1:0] resp_thld_o,

  input  queue_status_t        cmd_status_i,
  input  queue_status_t        resp_status_i,

  input  addr_upd_t            addr_upd_i
);

  hci_reg_e             reg_sel;
  logic                 port_acc, bad_acc, reg_wr;
  logic [CsrDataW-1:0]  rd_mux;

  logic                 cmd_rst_q, resp_rst_q;
  logic [QueueCntW-1:0] cmd_thld_q, resp_thld_q;
  logic [DevAddrW-1:0]  dyn_addr_q;
  logic                 addr_valid_q;

  logic                 rd_ack_q, rd_err_q, wr_ack_q, wr_err_q;
  logic [CsrDataW-1:0]  rd_data_q;

  assign reg_sel = hci_reg_e'(csr_req_i.addr);

  // Port accesses go straight to the queues
  assign cmd_wr_o    = csr_req_i.req && csr_req_i.is_wr && (reg_sel == REG_COMMAND_PORT);
  assign resp_rd_o   = csr_req_i.req && !csr_req_i.is_wr && (reg_sel == REG_RESPONSE_PORT);
  assign cmd_wdata_o = csr_req_i.wr_data;
  assign port_acc    = cmd_wr_o || resp_rd_o;

  always_comb begin
    rd_mux  = '0;
    bad_acc = 1'b0;
    case (reg_sel)
      REG_RESET_CONTROL: begin
        rd_mux[RstCmdQueueBit]  = cmd_rst_q;
        rd_mux[RstRespQueueBit] = resp_rst_q;
      end
      REG_QUEUE_THLD: begin
        rd_mux[ThldCmdLsb +: QueueCntW]  = cmd_thld_q;
        rd_mux[ThldRespLsb +: QueueCntW] = resp_thld_q;
      end
      REG_COMMAND_PORT:  bad_acc = !csr_req_i.is_wr;
      REG_RESPONSE_PORT: bad_acc = csr_req_i.is_wr;
      REG_QUEUE_STATUS: begin
        rd_mux[StatCmdFullBit]                = cmd_status_i.full;
        rd_mux[StatCmdEmptyBit]               = cmd_status_i.empty;
        rd_mux[StatRespFullBit]               = resp_status_i.full;
        rd_mux[StatRespEmptyBit]              = resp_status_i.empty;
        rd_mux[StatCmdCountLsb +: QueueCntW]  = cmd_status_i.count;
        rd_mux[StatRespCountLsb +: QueueCntW] = resp_status_i.count;
      end
      REG_DEVICE_ADDR: begin
        rd_mux[DevAddrLsb +: DevAddrW] = dyn_addr_q;
        rd_mux[DevAddrValidBit]        = addr_valid_q;
      end
      default: bad_acc = 1'b1;
    endcase
  end

  assign reg_wr = csr_req_i.req && csr_req_i.is_wr && !port_acc && !bad_acc;

  // Ack stage for plain registers and error responses
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ack_q  <= 1'b0;
      rd_err_q  <= 1'b0;
      wr_ack_q  <= 1'b0;
      wr_err_q  <= 1'b0;
      rd_data_q <= '0;
    end else begin
      rd_ack_q  <= csr_req_i.req && !port_acc && !csr_req_i.is_wr;
      rd_err_q  <= csr_req_i.req && !port_acc && !csr_req_i.is_wr && bad_acc;
      wr_ack_q  <= csr_req_i.req && !port_acc && csr_req_i.is_wr;
      wr_err_q  <= csr_req_i.req && !port_acc && csr_req_i.is_wr && bad_acc;
      rd_data_q <= rd_mux;  // Zero on bad offsets
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_rst_q   <= 1'b0;
      resp_rst_q  <= 1'b0;
      cmd_thld_q  <= '0;
      resp_thld_q <= '0;
    end else begin
      // Self-clearing once the queue reports the flush
      if (cmd_flush_done_i) cmd_rst_q <= 1'b0;
      if (resp_flush_done_i) resp_rst_q <= 1'b0;
      if (reg_wr && reg_sel == REG_RESET_CONTROL) begin
        if (csr_req_i.wr_data[RstCmdQueueBit]) cmd_rst_q <= 1'b1;
        if (csr_req_i.wr_data[RstRespQueueBit]) resp_rst_q <= 1'b1;
      end
      if (reg_wr && reg_sel == REG_QUEUE_THLD) begin
        cmd_thld_q  <= csr_req_i.wr_data[ThldCmdLsb +: QueueCntW];
        resp_thld_q <= csr_req_i.wr_data[ThldRespLsb +: QueueCntW];
      end
    end
  end

  // SETDASA over RSTDAA over SETNEWDA
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dyn_addr_q   <= '0;
      addr_valid_q <= 1'b0;
    end else if (addr_upd_i.set_dasa) begin
      dyn_addr_q   <= addr_upd_i.addr;
      addr_valid_q <= 1'b1;
    end else if (addr_upd_i.rstdaa) begin
      dyn_addr_q   <= '0;
      addr_valid_q <= 1'b0;
    end else if (addr_upd_i.set_newda) begin
      dyn_addr_q   <= addr_upd_i.addr;
      addr_valid_q <= 1'b1;
    end
  end

  assign cmd_flush_o  = cmd_rst_q;
  assign resp_flush_o = resp_rst_q;
  assign cmd_thld_o   = cmd_thld_q;
  assign resp_thld_o  = resp_thld_q;

  assign csr_rsp_o.rd_ack  = rd_ack_q || resp_ack_i;
  assign csr_rsp_o.rd_err  = rd_err_q;
  assign csr_rsp_o.rd_data = resp_ack_i ? resp_data_i : rd_data_q;
  assign csr_rsp_o.wr_ack  = wr_ack_q || cmd_ack_i;
  assign csr_rsp_o.wr_err  = wr_err_q;

endmodule : hci_csr

/* logic/hci_resp_queue.sv */
// ==========================================================================
// A read on an empty queue waits for the next response before it is acked
// ==========================================================================
`timescale 1ns/10ps

module hci_resp_queue
  import hci_pkg::*;
#(
  parameter int unsigned Depth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,

  input  ctrl_resp_t           resp_i,
  output logic                 resp_wready_o,

  input  logic                 port_rd_i,
  output logic                 port_ack_o,
  output logic [RespDataW-1:0] port_data_o,

  input  logic [QueueCntW-1:0] thld_i,
  output queue_status_t        status_o,
  output logic                 flush_done_o
);

  logic                 rd_pend_q, done_q, ack_q;
  logic [RespDataW-1:0] data_q;
  logic                 fifo_rvalid, pop;
  logic [RespDataW-1:0] fifo_rdata;

  assign pop = (port_rd_i || rd_pend_q) && fifo_rvalid && !flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pend_q <= 1'b0;
      done_q    <= 1'b0;
      ack_q     <= 1'b0;
      data_q    <= '0;
    end else begin
      done_q    <= flush_i && !done_q;
      rd_pend_q <= (port_rd_i || rd_pend_q) && !pop;  // Held until an entry shows up
      ack_q     <= pop;
      if (pop) data_q <= fifo_rdata;
    end
  end

  assign port_ack_o   = ack_q;
  assign port_data_o  = data_q;
  assign flush_done_o = done_q;

  hci_fifo #(
    .Depth      (Depth),
    .DataW      (RespDataW),
    .ThldOnFree (1'b0)
  ) fifo_i (
    .clk_i,
    .rst_ni,
    .flush_i,
    .wvalid_i (resp_i.wvalid),
    .wdata_i  (resp_i.wdata),
    .wready_o (resp_wready_o),
    .rvalid_o (fifo_rvalid),
    .rdata_o  (fifo_rdata),
    .rready_i (pop),
    .thld_i,
    .status_o
  );

endmodule : hci_resp_queue

/* logic/hci_cmd_queue.sv */
// ==========================================================================
// Two port dwords form one command, low dword first. Full queue stalls ack
// ==========================================================================
`timescale 1ns/10ps

module hci_cmd_queue
  import hci_pkg::*;
  import hci_csr_pkg::*;
#(
  parameter int unsigned Depth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,

  input  logic                 port_wr_i,
  input  logic [CsrDataW-1:0]  port_data_i,
  output logic                 port_ack_o,

  input  logic [QueueCntW-1:0] thld_i,

  output ctrl_cmd_t            cmd_o,
  input  logic                 cmd_rready_i,

  output queue_status_t        status_o,
  output logic                 flush_done_o
);

  cmd_asm_e            state_q;
  logic                pend_q;
  logic                done_q;
  logic [CsrDataW-1:0] pend_data_q;
  logic [CsrDataW-1:0] low_q;
  logic [CmdDataW-1:0] fifo_wdata;
  logic                fifo_wvalid, fifo_wready;

  assign fifo_wvalid = pend_q && (state_q == CMD_HIGH);
  assign fifo_wdata  = {pend_data_q, low_q};

  // Low half only needs the holding register
  assign port_ack_o = pend_q && !flush_i && ((state_q == CMD_LOW) || fifo_wready);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CMD_LOW;
      pend_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= flush_i && !done_q;  // Single pulse per flush
      if (port_wr_i) begin
        pend_q <= 1'b1;
      end else if (port_ack_o) begin
        pend_q <= 1'b0;
      end
      if (flush_i) begin
        state_q <= CMD_LOW;
      end else if (port_ack_o) begin
        state_q <= (state_q == CMD_LOW) ? CMD_HIGH : CMD_LOW;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (port_wr_i) pend_data_q <= port_data_i;
    if (port_ack_o && state_q == CMD_LOW) low_q <= pend_data_q;
  end

  assign flush_done_o = done_q;

  hci_fifo #(
    .Depth      (Depth),
    .DataW      (CmdDataW),
    .ThldOnFree (1'b1)
  ) fifo_i (
    .clk_i,
    .rst_ni,
    .flush_i,
    .wvalid_i (fifo_wvalid),
    .wdata_i  (fifo_wdata),
    .wready_o (fifo_wready),
    .rvalid_o (cmd_o.rvalid),
    .rdata_o  (cmd_o.rdata),
    .rready_i (cmd_rready_i),
    .thld_i,
    .status_o
  );

endmodule : hci_cmd_queue

/* logic/hci_fifo.sv */
// ==========================================================================
// Depth must be below 256. Flush wins over a push or pop in the same cycle
// ==========================================================================
`timescale 1ns/10ps

module hci_fifo
  import hci_pkg::*;
#(
  parameter int unsigned Depth      = 8,
  parameter int unsigned DataW      = 32,
  parameter bit          ThldOnFree = 1'b0  // Trigger on free slots, not on entries
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,

  input  logic                 wvalid_i,
  input  logic [DataW-1:0]     wdata_i,
  output logic                 wready_o,

  output logic                 rvalid_o,
  output logic [DataW-1:0]     rdata_o,
  input  logic                 rready_i,

  input  logic [QueueCntW-1:0] thld_i,
  output queue_status_t        status_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam logic [QueueCntW-1:0] DepthCnt = QueueCntW'(Depth);
  localparam logic [PtrW-1:0] LastPtr = PtrW'(Depth - 1);

  logic [DataW-1:0]     mem_q [Depth];
  logic [PtrW-1:0]      wr_ptr_q, rd_ptr_q;
  logic [QueueCntW-1:0] count_q;
  logic [QueueCntW-1:0] level, thld_eff;
  logic                 full, empty, push, pop;

  assign full  = (count_q == DepthCnt);
  assign empty = (count_q == '0);
  assign push  = wvalid_i && !full && !flush_i;
  assign pop   = rvalid_o && rready_i && !flush_i;

  assign wready_o = !full;
  assign rvalid_o = !empty;
  assign rdata_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= wdata_i;
  end

  // Threshold of 0 behaves as 1
  assign thld_eff = (thld_i == '0) ? QueueCntW'(1) : thld_i;
  assign level    = ThldOnFree ? (DepthCnt - count_q) : count_q;

  assign status_o.full      = full;
  assign status_o.empty     = empty;
  assign status_o.count     = count_q;
  assign status_o.thld_trig = (level >= thld_eff);

endmodule : hci_fifo

/* logic/hci_csr_pkg.sv */
// ==========================================================================
// CPU register map. Offsets are byte addresses, all accesses are full dwords
// ==========================================================================
package hci_csr_pkg;

  localparam int unsigned CsrAddrW = 12;
  localparam int unsigned CsrDataW = 32;

  typedef enum logic [CsrAddrW-1:0] {
    REG_RESET_CONTROL = 12'h000,
    REG_QUEUE_THLD    = 12'h004,
    REG_COMMAND_PORT  = 12'h008,  // Write only
    REG_RESPONSE_PORT = 12'h00C,  // Read only
    REG_QUEUE_STATUS  = 12'h010,
    REG_DEVICE_ADDR   = 12'h014
  } hci_reg_e;

  typedef struct packed {
    logic                req;
    logic                is_wr;
    logic [CsrAddrW-1:0] addr;
    logic [CsrDataW-1:0] wr_data;
  } csr_req_t;

  typedef struct packed {
    logic                rd_ack;
    logic                rd_err;
    logic [CsrDataW-1:0] rd_data;
    logic                wr_ack;
    logic                wr_err;
  } csr_rsp_t;

  // RESET_CONTROL
  localparam int unsigned RstCmdQueueBit  = 1;
  localparam int unsigned RstRespQueueBit = 2;
  // QUEUE_THLD
  localparam int unsigned ThldCmdLsb  = 0;
  localparam int unsigned ThldRespLsb = 8;
  // QUEUE_STATUS
  localparam int unsigned StatCmdFullBit   = 0;
  localparam int unsigned StatCmdEmptyBit  = 1;
  localparam int unsigned StatRespFullBit  = 2;
  localparam int unsigned StatRespEmptyBit = 3;
  localparam int unsigned StatCmdCountLsb  = 8;
  localparam int unsigned StatRespCountLsb = 16;
  // DEVICE_ADDR
  localparam int unsigned DevAddrLsb      = 0;
  localparam int unsigned DevAddrValidBit = 31;

endpackage : hci_csr_pkg

/* logic/hci_pkg.sv */
// ==========================================================================
// Queue-side widths and types. Queue depths must stay below 256 entries
// ==========================================================================
package hci_pkg;

  localparam int unsigned CmdDataW  = 64;  // Two command-port dwords
  localparam int unsigned RespDataW = 32;
  localparam int unsigned QueueCntW = 8;
  localparam int unsigned DevAddrW  = 7;

  // Which half of a command the next port write fills
  typedef enum logic {
    CMD_LOW  = 1'b0,
    CMD_HIGH = 1'b1
  } cmd_asm_e;

  typedef struct packed {
    logic                 full;
    logic                 empty;
    logic [QueueCntW-1:0] count;
    logic                 thld_trig;
  } queue_status_t;

  typedef struct packed {
    logic                rvalid;
    logic [CmdDataW-1:0] rdata;
  } ctrl_cmd_t;

  typedef struct packed {
    logic                 wvalid;
    logic [RespDataW-1:0] wdata;
  } ctrl_resp_t;

  // Address assignment strobes from the bus side
  typedef struct packed {
    logic                set_dasa;
    logic                rstdaa;
    logic                set_newda;
    logic [DevAddrW-1:0] addr;  // Shared by both set strobes
  } addr_upd_t;

endpackage : hci_pkg
